// File: src/alu_params.svh
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

`define ALU_DATA_W  64
`define ALU_FLAGS_W 6
`define ALU_OP_W    8
`define ALU_COND_W  4

// opcode 8'h00 is left unused, so an idle register decodes to no flags
`define OP_ADD64    8'h01
`define OP_ADD32    8'h02
`define OP_SUB64    8'h03
`define OP_SUB32    8'h04
`define OP_CMP16    8'h05
`define OP_CMP8     8'h06
`define OP_AND64    8'h07
`define OP_AND32    8'h08
`define OP_OR64     8'h09
`define OP_OR32     8'h0a
`define OP_XOR64    8'h0b
`define OP_XOR32    8'h0c
`define OP_NXOR64   8'h0d
`define OP_NXOR32   8'h0e
`define OP_MOV64    8'h0f
`define OP_MOV32    8'h10
`define OP_ZXT8_64  8'h11
`define OP_ZXT16_64 8'h12
`define OP_SXT8_64  8'h13
`define OP_SXT16_64 8'h14
`define OP_SXT32_64 8'h15
`define OP_CMOV64   8'h16
`define OP_CSET     8'h17
`define OP_LAHF     8'h18

// x86 condition codes, odd code is the inverse of the even one
`define COND_Z   4'h0
`define COND_NZ  4'h1
`define COND_S   4'h2
`define COND_NS  4'h3
`define COND_UGT 4'h4
`define COND_ULE 4'h5
`define COND_UGE 4'h6
`define COND_ULT 4'h7
`define COND_SGT 4'h8
`define COND_SLE 4'h9
`define COND_SGE 4'ha
`define COND_SLT 4'hb
`define COND_O   4'hc
`define COND_NO  4'hd
`define COND_P   4'he
`define COND_NP  4'hf

`endif

// File: src/alu_pkg.sv
`default_nettype none

`include "alu_params.svh"

package alu_pkg;

  typedef logic [`ALU_DATA_W-1:0]  data_t;
  typedef logic [`ALU_FLAGS_W-1:0] flags_t;  // {C,O,A,S,Z,P}, C on top
  typedef logic [`ALU_OP_W-1:0]    op_t;
  typedef logic [`ALU_COND_W-1:0]  cond_t;

endpackage

`default_nettype wire

// File: src/cond_eval.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module cond_eval (
  input  alu_pkg::flags_t flags,
  input  alu_pkg::cond_t  cond,
  output logic            take
);

  always_comb begin
    logic c;
    logic o;
    logic s;
    logic z;
    logic p;
    {c, o} = flags[5:4];  // A is not tested by any condition
    {s, z, p} = flags[2:0];
    case (cond)
      `COND_Z:   take = z;
      `COND_NZ:  take = ~z;
      `COND_S:   take = s;
      `COND_NS:  take = ~s;
      `COND_UGT: take = c & ~z;  // C set means no borrow
      `COND_ULE: take = ~c | z;
      `COND_UGE: take = c;
      `COND_ULT: take = ~c;
      `COND_SGT: take = ~(s ^ o) & ~z;
      `COND_SLE: take = (s ^ o) | z;
      `COND_SGE: take = ~(s ^ o);
      `COND_SLT: take = s ^ o;
      `COND_O:   take = o;
      `COND_NO:  take = ~o;
      `COND_P:   take = p;
      `COND_NP:  take = ~p;
      default:   take = 1'b0;
    endcase
    if (!$isunknown({flags, cond})) begin
      a_take_known: assert (!$isunknown(take))
        else $error("cond_eval: take unknown for cond %h", cond);
    end
  end

endmodule

`default_nettype wire

// File: src/int_adder.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module int_adder (
  input  alu_pkg::data_t a,
  input  alu_pkg::data_t b,
  input  alu_pkg::op_t   op,
  output alu_pkg::data_t sum,
  output logic [4:0]     carry  // out of bits 3, 7, 15, 31, 63
);

  import alu_pkg::*;

  logic  sub;
  data_t b_eff;
  logic  c3;
  logic  c7;
  logic  c15;
  logic  c31;
  logic  c63;

  assign sub = (op == `OP_SUB64) || (op == `OP_SUB32) ||
               (op == `OP_CMP16) || (op == `OP_CMP8);

  assign b_eff = sub ? ~b : b;  // a + ~b + 1

  // chained so every flag width sees its own carry
  assign {c3, sum[3:0]} = {1'b0, a[3:0]} + {1'b0, b_eff[3:0]} + {4'b0, sub};
  assign {c7, sum[7:4]} = {1'b0, a[7:4]} + {1'b0, b_eff[7:4]} + {4'b0, c3};
  assign {c15, sum[15:8]} = {1'b0, a[15:8]} + {1'b0, b_eff[15:8]} + {8'b0, c7};
  assign {c31, sum[31:16]} = {1'b0, a[31:16]} + {1'b0, b_eff[31:16]} + {16'b0, c15};
  assign {c63, sum[63:32]} = {1'b0, a[63:32]} + {1'b0, b_eff[63:32]} + {32'b0, c31};

  assign carry = {c63, c31, c15, c7, c3};

endmodule

`default_nettype wire

// File: src/result_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module result_mux (
  input  logic           in_valid,
  input  alu_pkg::data_t a,
  input  alu_pkg::data_t b,
  input  alu_pkg::data_t sum,
  input  alu_pkg::op_t   op,
  input  logic           take,
  output alu_pkg::data_t result
);

  always_comb begin
    case (op)
      `OP_ADD64, `OP_SUB64: result = sum;
      `OP_ADD32, `OP_SUB32: result = {32'b0, sum[31:0]};
      `OP_CMP16:            result = {48'b0, sum[15:0]};
      `OP_CMP8:             result = {56'b0, sum[7:0]};

      `OP_AND64:  result = a & b;
      `OP_AND32:  result = {32'b0, a[31:0] & b[31:0]};
      `OP_OR64:   result = a | b;
      `OP_OR32:   result = {32'b0, a[31:0] | b[31:0]};
      `OP_XOR64:  result = a ^ b;
      `OP_XOR32:  result = {32'b0, a[31:0] ^ b[31:0]};
      `OP_NXOR64: result = ~(a ^ b);
      `OP_NXOR32: result = {32'b0, ~(a[31:0] ^ b[31:0])};

      // moves and extensions take the source from b
      `OP_MOV64:    result = b;
      `OP_MOV32:    result = {32'b0, b[31:0]};
      `OP_ZXT8_64:  result = {56'b0, b[7:0]};
      `OP_ZXT16_64: result = {48'b0, b[15:0]};
      `OP_SXT8_64:  result = {{56{b[7]}}, b[7:0]};
      `OP_SXT16_64: result = {{48{b[15]}}, b[15:0]};
      `OP_SXT32_64: result = {{32{b[31]}}, b[31:0]};

      `OP_CMOV64: result = take ? b : a;  // a is the old destination
      `OP_CSET:   result = {63'b0, take};
      `OP_LAHF:   result = '0;  // flags only

      default: begin
        result = '0;
        a_known_op: assert (!in_valid)
          else $error("result_mux: unknown opcode %h", op);
      end
    endcase
  end

endmodule

`default_nettype wire

// File: src/flag_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module flag_gen (
  input  logic            clk,
  input  logic            rst,
  input  logic            in_valid,
  input  logic            thread,
  input  logic            except,
  input  logic            except_thread,
  input  logic            flags_en,
  input  alu_pkg::op_t    op,
  input  alu_pkg::data_t  a,
  input  alu_pkg::data_t  b,
  input  alu_pkg::data_t  result,
  input  logic [4:0]      carry,
  output logic            res_valid,
  output alu_pkg::data_t  res,
  output alu_pkg::flags_t flags_out,
  output logic            flags_write
);

  import alu_pkg::*;

  logic       valid_q;
  logic       flags_en_q;
  op_t        op_q;
  data_t      res_q;
  data_t      a_q;
  data_t      b_q;
  logic [4:0] carry_q;
  logic       except_q;
  logic       except_thread_q;
  logic       kill;
  logic       sub_q;

  // carries come from a + ~b + 1 when subtracting
  function automatic flags_t add_flags(input logic c, input logic sa, input logic sb,
                                       input logic sr, input logic z, input logic c3,
                                       input logic sub);
    logic o;
    o = (sa == (sb ^ sub)) && (sr != sa);
    return {c, o, c3 ^ sub, sr, z, 1'b0};
  endfunction

  // same-thread exception this cycle or the one before
  assign kill = (except && (except_thread == thread)) ||
                (except_q && (except_thread_q == thread));

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q         <= 1'b0;
      flags_en_q      <= 1'b0;
      op_q            <= '0;
      res_q           <= '0;
      except_q        <= 1'b0;
      except_thread_q <= 1'b0;
    end else begin
      valid_q         <= in_valid && !kill;
      flags_en_q      <= flags_en;
      op_q            <= op;
      res_q           <= result;
      except_q        <= except;
      except_thread_q <= except_thread;
    end
  end

  always_ff @(posedge clk) begin
    a_q     <= a;
    b_q     <= b;
    carry_q <= carry;
  end

  assign sub_q = (op_q == `OP_SUB64) || (op_q == `OP_SUB32) ||
                 (op_q == `OP_CMP16) || (op_q == `OP_CMP8);

  always_comb begin
    case (op_q)
      `OP_ADD64, `OP_SUB64:
        flags_out = add_flags(carry_q[4], a_q[63], b_q[63], res_q[63],
                              res_q == '0, carry_q[0], sub_q);
      `OP_ADD32, `OP_SUB32:
        flags_out = add_flags(carry_q[3], a_q[31], b_q[31], res_q[31],
                              res_q[31:0] == '0, carry_q[0], sub_q);
      `OP_CMP16:
        flags_out = add_flags(carry_q[2], a_q[15], b_q[15], res_q[15],
                              res_q[15:0] == '0, carry_q[0], sub_q);
      `OP_CMP8:
        flags_out = add_flags(carry_q[1], a_q[7], b_q[7], res_q[7],
                              res_q[7:0] == '0, carry_q[0], sub_q);
      `OP_AND64, `OP_OR64, `OP_XOR64, `OP_NXOR64:
        flags_out = {3'b0, res_q[63], res_q == '0, 1'b0};
      `OP_AND32, `OP_OR32, `OP_XOR32, `OP_NXOR32:
        flags_out = {3'b0, res_q[31], res_q[31:0] == '0, 1'b0};
      `OP_LAHF:
        flags_out = a_q[5:0];
      default:
        flags_out = '0;
    endcase
  end

  assign res_valid   = valid_q;
  assign res         = res_q;
  assign flags_write = valid_q && flags_en_q;

  a_write_valid: assert property (@(posedge clk) disable iff (rst)
    flags_write |-> res_valid);

endmodule

`default_nettype wire

// File: src/alu_top.sv
`timescale 1ns/1ps
`default_nettype none

module alu_top (
  input  logic            clk,
  input  logic            rst,
  input  logic            in_valid,
  input  alu_pkg::op_t    op,
  input  alu_pkg::cond_t  cond,
  input  alu_pkg::data_t  a,
  input  alu_pkg::data_t  b,
  input  alu_pkg::flags_t flags_in,
  input  logic            flags_en,
  input  logic            thread,
  input  logic            except,
  input  logic            except_thread,
  output logic            res_valid,
  output alu_pkg::data_t  res,
  output alu_pkg::flags_t flags_out,
  output logic            flags_write
);

  import alu_pkg::*;

  logic       take;
  data_t      sum;
  data_t      result;
  logic [4:0] carry;

  cond_eval u_cond (
    .flags (flags_in),
    .cond  (cond),
    .take  (take)
  );

  int_adder u_adder (
    .a     (a),
    .b     (b),
    .op    (op),
    .sum   (sum),
    .carry (carry)
  );

  result_mux u_mux (
    .in_valid (in_valid),
    .a        (a),
    .b        (b),
    .sum      (sum),
    .op       (op),
    .take     (take),
    .result   (result)
  );

  flag_gen u_flags (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .thread        (thread),
    .except        (except),
    .except_thread (except_thread),
    .flags_en      (flags_en),
    .op            (op),
    .a             (a),
    .b             (b),
    .result        (result),
    .carry         (carry),
    .res_valid     (res_valid),
    .res           (res),
    .flags_out     (flags_out),
    .flags_write   (flags_write)
  );

endmodule

`default_nettype wire

// File: test/alu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module alu_checker (
  input  logic        clk,
  input  logic        rst,
  input  logic        in_valid,
  input  int          vec_idx,
  input  logic        res_valid,
  input  logic [63:0] res,
  input  logic [5:0]  flags_out,
  input  logic        flags_write,
  input  logic        done,
  output int          errors,
  output logic        report_done
);

  localparam int FIELDS = 13;

  logic [63:0] stim [0:FIELDS*64-1];
  int          pend[$];   // issued vector indices
  logic        check_now;
  logic        test_open;
  logic [7:0]  cur_test;
  int          test_errs;
  int          tests_run;
  int          tests_failed;
  int          vectors;

  initial begin
    $readmemh("test/alu_stimulus.txt", stim);
    errors       = 0;
    report_done  = 1'b0;
    check_now    = 1'b0;
    test_open    = 1'b0;
    cur_test     = 8'h00;
    test_errs    = 0;
    tests_run    = 0;
    tests_failed = 0;
    vectors      = 0;
  end

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h expected %h (test %0d)", name, got, exp, cur_test);
      errors++;
      test_errs++;
    end
  endtask

  task automatic close_test();
    if (test_open) begin
      tests_run++;
      if (test_errs == 0) begin
        $display("test %0d done: ok", cur_test);
      end else begin
        $display("test %0d done: %0d errors", cur_test, test_errs);
        tests_failed++;
      end
    end
  endtask

  task automatic check_vector(input int idx);
    int   base;
    logic kill;
    logic fw;
    base = idx * FIELDS;
    if (!test_open || stim[base][7:0] != cur_test) begin
      close_test();
      test_open = 1'b1;
      cur_test  = stim[base][7:0];
      test_errs = 0;
    end
    vectors++;
    kill = stim[base+10][0];
    fw   = stim[base+6][0] && !kill;  // killed results write no flags
    compare_value("res_valid", {63'd0, res_valid}, {63'd0, !kill});
    compare_value("flags_write", {63'd0, flags_write}, {63'd0, fw});
    if (!kill) begin
      compare_value("res", res, stim[base+11]);
      compare_value("flags_out", {58'd0, flags_out}, {58'd0, stim[base+12][5:0]});
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      check_now = 1'b0;
    end else begin
      check_now = in_valid;
      if (in_valid) pend.push_back(vec_idx);
    end
  end

  // outputs are settled by the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      if (check_now) begin
        check_vector(pend.pop_front());
      end else if (res_valid) begin
        $display("res_valid was raised with no instruction issued");
        errors++;
      end
      if (done && !report_done) begin
        close_test();
        $display("tests %0d, failed %0d, vectors %0d, errors %0d",
                 tests_run, tests_failed, vectors, errors);
        report_done = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: test/tb_alu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_alu;

  localparam int FIELDS = 13;   // words per vector in the data file
  localparam int MAX_VEC = 64;

  logic        clk;
  logic        rst;
  logic        in_valid;
  logic [7:0]  op;
  logic [3:0]  cond;
  logic [63:0] a;
  logic [63:0] b;
  logic [5:0]  flags_in;
  logic        flags_en;
  logic        thread;
  logic        except;
  logic        except_thread;
  logic        res_valid;
  logic [63:0] res;
  logic [5:0]  flags_out;
  logic        flags_write;

  logic [63:0] stim [0:FIELDS*MAX_VEC-1];
  int          vec_idx;
  int          n_vec;
  int          cycles;
  int          limit;
  int          errors;
  int          gap;
  int          seed_val;
  logic        done;
  logic        report_done;

  alu_top u_dut (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .op            (op),
    .cond          (cond),
    .a             (a),
    .b             (b),
    .flags_in      (flags_in),
    .flags_en      (flags_en),
    .thread        (thread),
    .except        (except),
    .except_thread (except_thread),
    .res_valid     (res_valid),
    .res           (res),
    .flags_out     (flags_out),
    .flags_write   (flags_write)
  );

  alu_checker u_chk (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .vec_idx     (vec_idx),
    .res_valid   (res_valid),
    .res         (res),
    .flags_out   (flags_out),
    .flags_write (flags_write),
    .done        (done),
    .errors      (errors),
    .report_done (report_done)
  );

  always #20 clk = ~clk;

  // idle inputs between vectors, no exception either
  task automatic idle_inputs();
    in_valid      = 1'b0;
    op            = 8'h00;
    cond          = 4'h0;
    a             = '0;
    b             = '0;
    flags_in      = '0;
    flags_en      = 1'b0;
    thread        = 1'b0;
    except        = 1'b0;
    except_thread = 1'b0;
  endtask

  task automatic drive_vector(input int idx);
    int base;
    base          = idx * FIELDS;
    vec_idx       = idx;
    in_valid      = 1'b1;
    op            = stim[base+1][7:0];
    cond          = stim[base+2][3:0];
    flags_in      = stim[base+3][5:0];
    a             = stim[base+4];
    b             = stim[base+5];
    flags_en      = stim[base+6][0];
    thread        = stim[base+7][0];
    except        = stim[base+8][0];
    except_thread = stim[base+9][0];
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("timeout: run did not end within %0d cycles", limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    done     = 1'b0;
    vec_idx  = 0;
    cycles   = 0;
    seed_val = $urandom(32'hda2a);
    idle_inputs();
    $readmemh("test/alu_stimulus.txt", stim);
    n_vec = 0;
    while (n_vec < MAX_VEC && stim[n_vec*FIELDS][7:0] != 8'hff)
      n_vec++;
    limit = n_vec * 4 + 40;

    repeat (10) @(posedge clk);
    #2 rst = 1'b0;

    for (int i = 0; i < n_vec; i++) begin
      @(posedge clk);
      #2 drive_vector(i);
      gap = except ? 0 : int'($urandom % 3);  // victim follows right away
      repeat (gap) begin
        @(posedge clk);
        #2 idle_inputs();
      end
    end
    @(posedge clk);
    #2 idle_inputs();
    repeat (2) @(posedge clk);
    #2 done = 1'b1;
    wait (report_done);

    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/alu_stimulus.txt
// id op cond flags_in a b flags_en thread except except_thread kill res flags
// flags are {C,O,A,S,Z,P}, C in bit 5; a line with id ff ends the list
1 01 0 00 ffffffffffffffff 1 1 0 0 0 0 0 2a
1 01 0 00 7fffffffffffffff 1 1 0 0 0 0 8000000000000000 1c
1 03 0 00 3 5 1 0 0 0 0 fffffffffffffffe 0c
1 03 0 00 8000000000000000 1 1 0 0 0 0 7fffffffffffffff 38
1 02 0 00 00000001ffffffff 1 1 0 0 0 0 0 2a
1 04 0 00 0 1 1 0 0 0 0 00000000ffffffff 0c
1 05 0 00 1234 1234 1 0 0 0 0 0 22
1 06 0 00 7f ff 1 0 0 0 0 80 14
2 07 0 00 ff00ff00ff00ff00 f0f0f0f0f0f0f0f0 1 0 0 0 0 f000f000f000f000 04
2 0a 0 00 1234567800000001 0000000080000000 1 0 0 0 0 0000000080000001 04
2 0c 0 00 ffffffff12345678 0000000012345678 1 0 0 0 0 0 02
2 0e 0 00 ffffffff00000000 0 1 0 0 0 0 00000000ffffffff 04
3 0f 0 00 0 8123456789abcdef 0 0 0 0 0 8123456789abcdef 00
3 10 0 00 0 ffffffff89abcdef 0 0 0 0 0 0000000089abcdef 00
3 12 0 00 0 ffffffffffff8001 0 0 0 0 0 8001 00
3 13 0 00 0 0000000000001280 0 0 0 0 0 ffffffffffffff80 00
3 14 0 00 0 ffffffffffff7fff 0 0 0 0 0 7fff 00
3 15 0 00 0 0000000080000000 0 0 0 0 0 ffffffff80000000 00
4 17 0 02 0 0 0 0 0 0 0 1 00
4 17 1 02 0 0 0 0 0 0 0 0 00
4 17 2 04 0 0 0 0 0 0 0 1 00
4 17 3 00 0 0 0 0 0 0 0 1 00
4 17 4 20 0 0 0 0 0 0 0 1 00
4 17 5 22 0 0 0 0 0 0 0 1 00
4 17 6 00 0 0 0 0 0 0 0 0 00
4 17 7 20 0 0 0 0 0 0 0 0 00
4 16 8 14 1111111111111111 2222222222222222 0 0 0 0 0 2222222222222222 00
4 16 9 04 1111111111111111 2222222222222222 0 0 0 0 0 2222222222222222 00
4 16 a 10 1111111111111111 2222222222222222 0 0 0 0 0 1111111111111111 00
4 16 b 14 1111111111111111 2222222222222222 0 0 0 0 0 1111111111111111 00
4 16 c 10 1111111111111111 2222222222222222 0 0 0 0 0 2222222222222222 00
4 16 d 10 1111111111111111 2222222222222222 0 0 0 0 0 1111111111111111 00
4 16 e 01 1111111111111111 2222222222222222 0 0 0 0 0 2222222222222222 00
4 16 f 3e 1111111111111111 2222222222222222 0 0 0 0 0 2222222222222222 00
5 18 0 00 ffffffffffffffed 0 1 0 0 0 0 0 2d
5 18 0 00 0000000000000012 0 0 0 0 0 0 0 12
6 01 0 00 1 1 1 0 1 0 1 0 00
6 01 0 00 2 2 1 0 0 0 1 0 00
6 01 0 00 3 3 1 1 1 0 0 6 00
6 01 0 00 4 4 1 1 0 0 0 8 00
6 01 0 00 5 5 1 0 0 0 0 a 00
6 01 0 00 6 6 1 1 1 1 1 0 00
6 01 0 00 7 7 1 0 0 0 0 e 00
ff 0 0 0 0 0 0 0 0 0 0 0 0

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_alu
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: filelist.f
+incdir+src
src/alu_pkg.sv
src/cond_eval.sv
src/int_adder.sv
src/result_mux.sv
src/flag_gen.sv
src/alu_top.sv
test/alu_checker.sv
test/tb_alu.sv
